/* flash_pkg.sv */
package flash_pkg;

  // Serial timing, in clock cycles per bit
  localparam int BAUD_DIV = 16;

  // Marker that opens a frame
  localparam logic [7:0] START_BYTE = 8'hAA;

  // Word memory geometry
  localparam int MEM_ADDR_W = 8;
  localparam int MEM_WORDS = 256;

  // Frame decoding states
  typedef enum logic [1:0] {
    IDLE,
    ADDRESS,
    LENGTH,
    PAYLOAD
  } flash_state_e;

  // One received byte, valid for a single clock
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  // One word write into the memory
  typedef struct packed {
    logic                  en;
    logic [MEM_ADDR_W-1:0] addr;
    logic [31:0]           data;
  } mem_write_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
  input  logic                clk,
  input  logic                rst,
  input  logic                rx,
  output flash_pkg::rx_byte_t rx_byte
);
  import flash_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e   state;
  logic        rx_meta;
  logic        rx_sync;
  logic        rx_prev;
  logic [15:0] bit_timer;
  logic [2:0]  bit_count;
  logic [7:0]  shift_reg;

  // Two flop synchronizer plus one more stage for edge detection
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= RX_IDLE;
      bit_timer     <= '0;
      bit_count     <= '0;
      rx_byte.valid <= 1'b0;
    end else begin
      rx_byte.valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rx_prev && !rx_sync) begin
            state     <= RX_START;
            bit_timer <= '0;
          end
        end
        RX_START: begin
          // Half a bit later the start bit must still be low
          if (bit_timer == 16'(BAUD_DIV / 2 - 1)) begin
            bit_timer <= '0;
            bit_count <= '0;
            state     <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            bit_timer <= bit_timer + 16'd1;
          end
        end
        RX_DATA: begin
          if (bit_timer == 16'(BAUD_DIV - 1)) begin
            bit_timer <= '0;
            shift_reg <= {rx_sync, shift_reg[7:1]};
            if (bit_count == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_count <= bit_count + 3'd1;
            end
          end else begin
            bit_timer <= bit_timer + 16'd1;
          end
        end
        RX_STOP: begin
          // A low stop bit means a framing error, so no strobe
          if (bit_timer == 16'(BAUD_DIV - 1)) begin
            state         <= RX_IDLE;
            rx_byte.valid <= rx_sync;
            rx_byte.data  <= shift_reg;
          end else begin
            bit_timer <= bit_timer + 16'd1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

/* flash_frame_fsm.sv */
`timescale 1ns/10ps

module flash_frame_fsm (
  input  logic                                clk,
  input  logic                                rst,
  input  flash_pkg::rx_byte_t                 rx_byte,
  input  logic                                hdr_last,
  input  logic                                pay_last,
  output logic                                hdr_clear,
  output logic                                hdr_step,
  output logic                                len_load,
  output logic                                pay_step,
  output logic [31:0]                         len_value,
  output logic                                base_load,
  output logic [flash_pkg::MEM_ADDR_W-1:0]    base_word_addr,
  output logic                                pay_accept,
  output logic                                busy
);
  import flash_pkg::*;

  flash_state_e state;
  flash_state_e next_state;
  logic [31:0]  addr_shift;
  logic [31:0]  len_shift;
  logic [31:0]  len_full;

  // Length including the byte arriving right now, sent LSB first
  assign len_full  = {rx_byte.data, len_shift[31:8]};
  assign len_value = {len_full[31:2], 2'b00};

  // Byte address to word address, wrapped to the memory size
  assign base_word_addr = addr_shift[MEM_ADDR_W+1:2];

  assign busy       = (state != IDLE);
  assign pay_accept = (state == PAYLOAD);

  always_comb begin
    next_state = state;
    hdr_clear  = 1'b0;
    hdr_step   = 1'b0;
    len_load   = 1'b0;
    base_load  = 1'b0;
    pay_step   = 1'b0;
    case (state)
      IDLE: begin
        // Anything other than the start marker is dropped here
        if (rx_byte.valid && rx_byte.data == START_BYTE) begin
          hdr_clear  = 1'b1;
          next_state = ADDRESS;
        end
      end
      ADDRESS: begin
        if (rx_byte.valid) begin
          hdr_step = 1'b1;
          if (hdr_last) begin
            next_state = LENGTH;
          end
        end
      end
      LENGTH: begin
        if (rx_byte.valid) begin
          hdr_step = 1'b1;
          if (hdr_last) begin
            len_load   = 1'b1;
            base_load  = 1'b1;
            next_state = (len_value != 32'd0) ? PAYLOAD : IDLE;
          end
        end
      end
      PAYLOAD: begin
        if (rx_byte.valid) begin
          pay_step = 1'b1;
          if (pay_last) begin
            next_state = IDLE;
          end
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Header fields shift in at the top so the last byte lands in [31:24]
  always_ff @(posedge clk) begin
    if (rx_byte.valid && state == ADDRESS) begin
      addr_shift <= {rx_byte.data, addr_shift[31:8]};
    end
    if (rx_byte.valid && state == LENGTH) begin
      len_shift <= len_full;
    end
  end

endmodule

/* flash_byte_counter.sv */
`timescale 1ns/10ps

module flash_byte_counter (
  input  logic        clk,
  input  logic        rst,
  input  logic        hdr_clear,
  input  logic        hdr_step,
  input  logic        len_load,
  input  logic        pay_step,
  input  logic [31:0] len_value,
  output logic        hdr_last,
  output logic        pay_last
);

  logic [1:0]  hdr_idx;
  logic [31:0] pay_count;

  // Header byte index, shared by the address and length fields.
  // It wraps back to zero after the fourth byte of each field.
  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_idx <= 2'd0;
    end else if (hdr_clear) begin
      hdr_idx <= 2'd0;
    end else if (hdr_step) begin
      hdr_idx <= hdr_idx + 2'd1;
    end
  end

  // Payload bytes still to come in the open frame
  always_ff @(posedge clk) begin
    if (rst) begin
      pay_count <= 32'd0;
    end else if (len_load) begin
      pay_count <= len_value;
    end else if (pay_step && pay_count != 32'd0) begin
      pay_count <= pay_count - 32'd1;
    end
  end

  assign hdr_last = (hdr_idx == 2'd3);

  // Only the final payload byte is outstanding
  assign pay_last = (pay_count == 32'd1);

endmodule

/* flash_word_packer.sv */
`timescale 1ns/10ps

module flash_word_packer (
  input  logic                             clk,
  input  logic                             rst,
  input  flash_pkg::rx_byte_t              rx_byte,
  input  logic                             pay_accept,
  input  logic                             base_load,
  input  logic [flash_pkg::MEM_ADDR_W-1:0] base_word_addr,
  output flash_pkg::mem_write_t            mem_wr
);
  import flash_pkg::*;

  logic                  take_byte;
  logic [1:0]            lane;
  logic [MEM_ADDR_W-1:0] word_addr;
  logic [31:0]           word_reg;
  logic                  wr_en;
  logic [MEM_ADDR_W-1:0] wr_addr;

  assign take_byte = pay_accept && rx_byte.valid;

  // Control side of the packer
  always_ff @(posedge clk) begin
    if (rst) begin
      lane      <= 2'd0;
      word_addr <= '0;
      wr_en     <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (base_load) begin
        lane      <= 2'd0;
        word_addr <= base_word_addr;
      end else if (take_byte) begin
        lane <= lane + 2'd1;
        if (lane == 2'd3) begin
          wr_en     <= 1'b1;
          word_addr <= word_addr + 1'b1;
        end
      end
    end
  end

  // Bytes fill the word LSB first, the newest byte enters at the top
  always_ff @(posedge clk) begin
    if (take_byte) begin
      word_reg <= {rx_byte.data, word_reg[31:8]};
      if (lane == 2'd3) begin
        wr_addr <= word_addr;
      end
    end
  end

  // word_reg holds the finished word until the next payload byte
  assign mem_wr = '{en: wr_en, addr: wr_addr, data: word_reg};

endmodule

/* flash_word_mem.sv */
`timescale 1ns/10ps

module flash_word_mem (
  input  logic                             clk,
  input  flash_pkg::mem_write_t            mem_wr,
  input  logic [flash_pkg::MEM_ADDR_W-1:0] rd_addr,
  output logic [31:0]                      rd_data
);
  import flash_pkg::*;

  logic [31:0] mem [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (mem_wr.en) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* uart_flash_top.sv */
`timescale 1ns/10ps

module uart_flash_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rx,
  output logic                             busy,
  input  logic [flash_pkg::MEM_ADDR_W-1:0] rd_addr,
  output logic [31:0]                      rd_data
);
  import flash_pkg::*;

  rx_byte_t              rx_byte;
  mem_write_t            mem_wr;
  logic                  hdr_clear;
  logic                  hdr_step;
  logic                  len_load;
  logic                  pay_step;
  logic [31:0]           len_value;
  logic                  hdr_last;
  logic                  pay_last;
  logic                  base_load;
  logic [MEM_ADDR_W-1:0] base_word_addr;
  logic                  pay_accept;

  uart_rx i_uart_rx (
    .clk     (clk),
    .rst     (rst),
    .rx      (rx),
    .rx_byte (rx_byte)
  );

  flash_frame_fsm i_flash_frame_fsm (
    .clk            (clk),
    .rst            (rst),
    .rx_byte        (rx_byte),
    .hdr_last       (hdr_last),
    .pay_last       (pay_last),
    .hdr_clear      (hdr_clear),
    .hdr_step       (hdr_step),
    .len_load       (len_load),
    .pay_step       (pay_step),
    .len_value      (len_value),
    .base_load      (base_load),
    .base_word_addr (base_word_addr),
    .pay_accept     (pay_accept),
    .busy           (busy)
  );

  flash_byte_counter i_flash_byte_counter (
    .clk       (clk),
    .rst       (rst),
    .hdr_clear (hdr_clear),
    .hdr_step  (hdr_step),
    .len_load  (len_load),
    .pay_step  (pay_step),
    .len_value (len_value),
    .hdr_last  (hdr_last),
    .pay_last  (pay_last)
  );

  flash_word_packer i_flash_word_packer (
    .clk            (clk),
    .rst            (rst),
    .rx_byte        (rx_byte),
    .pay_accept     (pay_accept),
    .base_load      (base_load),
    .base_word_addr (base_word_addr),
    .mem_wr         (mem_wr)
  );

  flash_word_mem i_flash_word_mem (
    .clk     (clk),
    .mem_wr  (mem_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* tb_uart_flash_tasks.svh */
// Failure exit shared by every check and timeout
task automatic stop_on_failure(input string msg);
  $display("%s", msg);
  $display("TEST FAIL");
  $fatal(1, "Simulation stopped on the first failure");
endtask

task automatic check_word(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
  if (actual !== expected) begin
    stop_on_failure($sformatf("CHECK FAILED at %0d ns: %s expected 0x%08h, got 0x%08h",
                              $time, name, expected, actual));
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    stop_on_failure($sformatf("CHECK FAILED at %0d ns: %s expected %b, got %b",
                              $time, name, expected, actual));
  end
endtask

// One bit time on the line, changed on the falling clock edge
task automatic drive_bit(input logic value);
  @(negedge clk);
  rx = value;
  repeat (BAUD_DIV - 1) @(negedge clk);
endtask

// Start bit, data LSB first, stop bit, then one idle bit so a bad stop still leaves an edge
task automatic send_byte(input logic [7:0] data, input logic stop_bit);
  drive_bit(1'b0);
  for (int i = 0; i < 8; i++) begin
    drive_bit(data[i]);
  end
  drive_bit(stop_bit);
  drive_bit(1'b1);
endtask

task automatic read_word(input logic [MEM_ADDR_W-1:0] addr, output logic [31:0] data);
  @(negedge clk);
  rd_addr = addr;
  @(negedge clk);
  data = rd_data;
endtask

task automatic wait_idle();
  int cycles;
  cycles = 0;
  while (busy && cycles < 4 * BAUD_DIV) begin
    @(negedge clk);
    cycles++;
  end
  if (busy) begin
    stop_on_failure("busy stayed high after the last byte of the frame");
  end
endtask

// Header LSB first; payload byte bad_idx goes out with a low stop bit
task automatic send_frame(input logic [31:0] addr, input logic [31:0] len,
                          input byte_q_t payload, input int bad_idx);
  send_byte(START_BYTE, 1'b1);
  for (int i = 0; i < 4; i++) begin
    send_byte(addr[8*i +: 8], 1'b1);
  end
  for (int i = 0; i < 4; i++) begin
    send_byte(len[8*i +: 8], 1'b1);
  end
  // Frame stays open only for a nonzero rounded length
  check_bit("busy", len[31:2] != 30'd0, busy);
  foreach (payload[i]) begin
    send_byte(payload[i], i != bad_idx);
  end
  wait_idle();
endtask

/* tb_uart_flash.sv */
`timescale 1ns/10ps

module tb_uart_flash;
  import flash_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int unsigned RAND_SEED = 32'h4667b0f5;
  // Bytes per test: stray, basic, rounded, zero length, wrap, stop error
  localparam int TOTAL_BYTES = 3 + 41 + 19 + 9 + 25 + 18;
  // Ten bit times per byte, doubled for margin
  localparam longint TIMEOUT_NS = longint'(TOTAL_BYTES) * 10 * BAUD_DIV * CLK_PERIOD * 2;

  typedef logic [7:0] byte_q_t[$];

  logic                  clk;
  logic                  rst;
  logic                  rx;
  logic                  busy;
  logic [MEM_ADDR_W-1:0] rd_addr;
  logic [31:0]           rd_data;

  // Expected memory contents
  logic [31:0] exp_mem [MEM_WORDS];

  uart_flash_top i_uart_flash_top (
    .clk     (clk),
    .rst     (rst),
    .rx      (rx),
    .busy    (busy),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  `include "tb_uart_flash_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    stop_on_failure("Watchdog expired before the tests finished");
  end

  function automatic byte_q_t random_payload(input int count);
    byte_q_t data;
    for (int i = 0; i < count; i++) begin
      data.push_back(8'($urandom_range(255, 0)));
    end
    return data;
  endfunction

  // Word n lands at (address / 4) + n modulo the depth, LSB first
  task automatic model_frame(input logic [31:0] addr, input logic [31:0] len,
                             input byte_q_t data);
    logic [31:0] word_idx;
    for (int n = 0; n < int'(len >> 2); n++) begin
      word_idx = ((addr >> 2) + 32'(n)) % 32'(MEM_WORDS);
      exp_mem[word_idx[MEM_ADDR_W-1:0]] = {data[4*n+3], data[4*n+2], data[4*n+1], data[4*n]};
    end
  endtask

  task automatic verify_words(input int start, input int count);
    logic [31:0]           got;
    logic [MEM_ADDR_W-1:0] word;
    for (int i = 0; i < count; i++) begin
      word = MEM_ADDR_W'((start + i) % MEM_WORDS);
      read_word(word, got);
      check_word($sformatf("rd_data[word %0d]", word), exp_mem[word], got);
    end
  endtask

  task automatic test_stray_bytes();
    byte_q_t stray;
    stray = '{8'h00, 8'h55, 8'hAB};
    check_bit("busy", 1'b0, busy);
    foreach (stray[i]) begin
      send_byte(stray[i], 1'b1);
      check_bit("busy", 1'b0, busy);
    end
  endtask

  task automatic test_basic_frame();
    byte_q_t payload;
    payload = random_payload(32);
    model_frame(32'h40, 32'd32, payload);
    send_frame(32'h40, 32'd32, payload, -1);
    check_bit("busy", 1'b0, busy);
    verify_words(16, 8);
  endtask

  // Two trailing bytes follow the rounded payload and must be ignored
  task automatic test_rounded_length();
    byte_q_t payload;
    byte_q_t trailing;
    payload = random_payload(8);
    trailing = '{8'h11, 8'h22};
    model_frame(32'h40, 32'd10, payload);
    send_frame(32'h40, 32'd10, payload, -1);
    check_bit("busy", 1'b0, busy);
    foreach (trailing[i]) begin
      send_byte(trailing[i], 1'b1);
      check_bit("busy", 1'b0, busy);
    end
    verify_words(16, 3);
  endtask

  task automatic test_zero_length();
    byte_q_t none;
    send_frame(32'h40, 32'd0, none, -1);
    check_bit("busy", 1'b0, busy);
    verify_words(16, 8);
  endtask

  task automatic test_address_wrap();
    byte_q_t payload;
    payload = random_payload(16);
    model_frame(32'h3F8, 32'd16, payload);
    send_frame(32'h3F8, 32'd16, payload, -1);
    check_bit("busy", 1'b0, busy);
    verify_words(254, 4);
  endtask

  task automatic test_stop_bit_error();
    byte_q_t payload;
    byte_q_t accepted;
    payload = random_payload(9);
    // Byte 3 is dropped, later bytes move down one place
    accepted = payload;
    accepted.delete(3);
    model_frame(32'h100, 32'd8, accepted);
    send_frame(32'h100, 32'd8, payload, 3);
    check_bit("busy", 1'b0, busy);
    verify_words(64, 2);
  endtask

  initial begin
    rst = 1'b1;
    rx = 1'b1;
    rd_addr = '0;
    void'($urandom(RAND_SEED));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_stray_bytes();
    test_basic_frame();
    test_rounded_length();
    test_zero_length();
    test_address_wrap();
    test_stop_bit_error();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
flash_pkg.sv
uart_rx.sv
flash_frame_fsm.sv
flash_byte_counter.sv
flash_word_packer.sv
flash_word_mem.sv
uart_flash_top.sv
tb_uart_flash.sv

/* run.sh */
#!/bin/sh
# Build the UART flash loader testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_uart_flash -f src.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1
